/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpu_pkg.sv
      - verilog/cpu_pc_counter.sv
      - verilog/cpu_control.sv
      - verilog/cpu_decode.sv
      - verilog/cpu_regfile.sv
      - verilog/cpu_execute.sv
      - verilog/cpu_core.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/cpu_core_checker.sv
      - dv/cpu_core_tb.sv

/* cpu_core.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_pc_counter.sv
verilog/cpu_control.sv
verilog/cpu_decode.sv
verilog/cpu_regfile.sv
verilog/cpu_execute.sv
verilog/cpu_core.sv
dv/cpu_core_checker.sv
dv/cpu_core_tb.sv

/* dv/cpu_core_checker.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_checker #(
    parameter int MAX_WB = 64
) (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  logic           instr_valid,
    input  cpu_pkg::word_t instr,
    input  logic           ready,
    input  logic           done,
    input  cpu_pkg::wb_t   wb,
    input  cpu_pkg::wb_t   expected [MAX_WB],
    input  int             expected_count,
    input  logic           end_check,
    output int             mismatch_count,
    output int             extra_count,
    output int             missing_count
);
    import cpu_pkg::*;

    int seen_count;
    // Cycles since a HALT was accepted, or -1 while none is pending.
    int halt_age = -1;

    task automatic check_field(input string name, input logic [`SIZE_DATA-1:0] got,
                               input logic [`SIZE_DATA-1:0] want);
        if (got !== want) begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
            mismatch_count++;
        end
    endtask

    task automatic compare_writeback();
        wb_t want;
        if (seen_count >= expected_count) begin
            $display("extra writeback to register %0d for pc %h at %0t, none was expected",
                     wb.idx, wb.pc, $time);
            extra_count++;
        end else begin
            want = expected[seen_count];
            check_field("wb.is_sr", wb.is_sr, want.is_sr);
            check_field("wb.idx", wb.idx, want.idx);
            check_field("wb.value", wb.value, want.value);
            check_field("wb.pc", wb.pc, want.pc);
            seen_count++;
        end
    endtask

    // Ready drops one cycle after HALT is taken and done follows two cycles later.
    task automatic track_halt();
        if (halt_age >= 0) begin
            halt_age++;
            check_field("ready", ready, halt_age == 1);
            check_field("done", done, halt_age >= 4);
            if (halt_age >= 4) begin
                halt_age = -1;
            end
        end
        if (instr_valid && ready && (instr[`POS_OPC +: `SIZE_OPC] == OPC_HALT)) begin
            halt_age = 0;
        end
    endtask

    always @(negedge iw_clk) begin
        if (iw_rst) begin
            check_field("ready", ready, 1'b0);
            check_field("done", done, 1'b0);
            check_field("wb.valid", wb.valid, 1'b0);
            halt_age = -1;
        end else begin
            if (wb.valid) begin
                compare_writeback();
            end
            track_halt();
        end
    end

    always @(posedge end_check) begin
        if (seen_count < expected_count) begin
            missing_count = expected_count - seen_count;
            $display("missing writebacks: only %0d of %0d expected records appeared",
                     seen_count, expected_count);
        end
    end

endmodule

/* dv/cpu_core_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int MAX_LINES     = 64;
    localparam int COLS          = 7;
    localparam int RAW_WORDS     = 1 + MAX_LINES * COLS;
    localparam int READY_TIMEOUT = 40;
    localparam int DONE_TIMEOUT  = 40;

    logic  iw_clk;
    logic  iw_rst;
    logic  start;
    logic  instr_valid;
    word_t instr;
    logic  ready;
    wb_t   wb;
    logic  done;

    logic [`SIZE_DATA-1:0] test_raw [RAW_WORDS];
    word_t words    [MAX_LINES];
    logic  chained  [MAX_LINES];
    wb_t   expected [MAX_LINES];
    int    line_count;
    int    expected_count;
    int    seed;
    int    timeout_count;
    int    file_errors;
    logic  end_check;
    int    mismatch_count;
    int    extra_count;
    int    missing_count;

    cpu_core u_cpu_core (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .start       (start),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ready       (ready),
        .wb          (wb),
        .done        (done)
    );

    cpu_core_checker #(
        .MAX_WB (MAX_LINES)
    ) u_cpu_core_checker (
        .iw_clk         (iw_clk),
        .iw_rst         (iw_rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .ready          (ready),
        .done           (done),
        .wb             (wb),
        .expected       (expected),
        .expected_count (expected_count),
        .end_check      (end_check),
        .mismatch_count (mismatch_count),
        .extra_count    (extra_count),
        .missing_count  (missing_count)
    );

    initial begin
        iw_clk = 1'b0;
        forever #4 iw_clk = ~iw_clk;
    end

    // ####################################################################
    // Test data
    // ####################################################################

    task automatic load_tests();
        int  i;
        int  base;
        wb_t rec;
        $readmemh("dv/cpu_core_tests.txt", test_raw);
        line_count     = test_raw[0];
        expected_count = 0;
        if (line_count < 1 || line_count > MAX_LINES) begin
            $display("test file holds %0d instruction lines, allowed are 1 to %0d",
                     line_count, MAX_LINES);
            file_errors++;
            line_count = 0;
        end
        for (i = 0; i < line_count; i++) begin
            base       = 1 + i * COLS;
            words[i]   = test_raw[base];
            chained[i] = test_raw[base + 1][0];
            // Lines without a writeback add nothing to the expected list.
            if (test_raw[base + 2][0]) begin
                rec.valid = 1'b1;
                rec.is_sr = test_raw[base + 3][0];
                rec.idx   = test_raw[base + 4][`SIZE_REG-1:0];
                rec.value = test_raw[base + 5];
                rec.pc    = test_raw[base + 6];
                expected[expected_count] = rec;
                expected_count++;
            end
        end
    endtask

    function automatic int pick_gap();
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % 3;
    endfunction

    function automatic logic is_halt_word(input word_t w);
        return w[`POS_OPC +: `SIZE_OPC] == OPC_HALT;
    endfunction

    // ####################################################################
    // Driver
    // ####################################################################

    task automatic wait_for_ready(output logic ok);
        int waited;
        waited = 0;
        @(negedge iw_clk);
        while (!ready && waited < READY_TIMEOUT) begin
            @(negedge iw_clk);
            waited++;
        end
        ok = ready;
        if (!ok) begin
            $display("timeout: ready stayed low for %0d cycles", READY_TIMEOUT);
            timeout_count++;
        end
    endtask

    task automatic wait_for_done(output logic ok);
        int waited;
        waited = 0;
        @(negedge iw_clk);
        while (!done && waited < DONE_TIMEOUT) begin
            @(negedge iw_clk);
            waited++;
        end
        ok = done;
        if (!ok) begin
            $display("timeout: done did not rise within %0d cycles of the HALT", DONE_TIMEOUT);
            timeout_count++;
        end
    endtask

    task automatic pulse_start();
        @(posedge iw_clk);
        start <= 1'b1;
        @(posedge iw_clk);
        start <= 1'b0;
    endtask

    // Sends words from first up to and including the next HALT.
    task automatic run_segment(input int first, output int next, output logic ok);
        int   i;
        int   gap;
        logic ready_ok;
        logic halted;
        ok     = 1'b1;
        halted = 1'b0;
        i      = first;
        while (!halted && ok && i < line_count) begin
            gap = chained[i] ? 0 : pick_gap();
            repeat (gap) begin
                @(posedge iw_clk);
                instr_valid <= 1'b0;
            end
            wait_for_ready(ready_ok);
            if (!ready_ok) begin
                ok = 1'b0;
            end else begin
                @(posedge iw_clk);
                instr_valid <= 1'b1;
                instr       <= words[i];
                halted = is_halt_word(words[i]);
                i++;
            end
        end
        @(posedge iw_clk);
        instr_valid <= 1'b0;
        next = i;
    endtask

    task automatic report_and_finish();
        int total;
        total = mismatch_count + extra_count + missing_count + timeout_count + file_errors;
        $display("errors: %0d mismatch, %0d extra, %0d missing, %0d timeout, %0d file",
                 mismatch_count, extra_count, missing_count, timeout_count, file_errors);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin : main_flow
        int   seg_start;
        int   seg_next;
        logic run_ok;
        iw_rst      = 1'b1;
        start       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        end_check   = 1'b0;
        seed        = 99272;
        load_tests();
        repeat (5) @(posedge iw_clk);
        iw_rst <= 1'b0;
        run_ok    = (line_count > 0);
        seg_start = 0;
        while (run_ok && seg_start < line_count) begin
            pulse_start();
            run_segment(seg_start, seg_next, run_ok);
            if (run_ok) begin
                wait_for_done(run_ok);
            end
            seg_start = seg_next;
        end
        // A few idle cycles so that a stray writeback after done is still seen.
        repeat (4) @(posedge iw_clk);
        end_check = 1'b1;
        @(posedge iw_clk);
        report_and_finish();
    end

endmodule

/* dv/cpu_core_tests.txt */
// Columns: instruction, chained to the previous word, writeback expected, is_sr,
// register index, value, pc. The first number is the count of instruction lines.
1c
// Program one, the pc counts from 0 after the first start.
244123 0 1 0 1 000123 000000
248456 1 1 0 2 000456 000001
04c800 1 1 0 3 000456 000002
08c400 1 1 0 3 000579 000003
0cc800 1 1 0 3 fffedd 000004
10c000 1 1 0 3 000122 000005
254f0f 0 1 0 5 ffff0f 000006
154400 1 1 0 5 000103 000007
194800 1 1 0 5 000557 000008
1d4c00 0 1 0 5 000475 000009
280abc 0 0 0 0 000000 00000a
218def 1 1 0 6 abcdef 00000b
25c800 0 1 0 7 fff800 00000c
305800 0 1 1 1 abcdef 00000d
2e0400 1 1 0 8 abcdef 00000e
309400 0 1 1 2 000475 00000f
000000 0 0 0 0 000000 000010
2e4800 0 1 0 9 000475 000011
2e8000 0 1 0 a 000012 000012
804400 0 0 0 0 000000 000013
06e000 0 1 0 b abcdef 000014
fc0000 0 0 0 0 000000 000015
// Program two, after the second start the pc is back at 0.
2f0000 0 1 0 c 000000 000000
2747ff 0 1 0 d 0007ff 000001
0b7400 1 1 0 d 000ffe 000002
2f8400 0 1 0 e abcdef 000003
2fc000 0 1 0 f 000004 000004
fc0000 0 0 0 0 000000 000005

/* verilog/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control (
    input  logic iw_clk,
    input  logic iw_rst,
    input  logic start,
    input  logic halt_seen,
    output logic ready,
    output logic done,
    output logic clear_pc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } state_e;

    // Cycles between HALT leaving decode and the last writeback.
    localparam logic [1:0] DRAIN_CYCLES = 2'd2;

    state_e     state_q;
    state_e     state_d;
    logic [1:0] drain_cnt_q;
    logic       drain_done;

    assign clear_pc   = start && ((state_q == ST_IDLE) || (state_q == ST_DONE));
    assign drain_done = (state_q == ST_DRAIN) && (drain_cnt_q == DRAIN_CYCLES - 2'd1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (start) state_d = ST_RUN;
            ST_RUN:   if (halt_seen) state_d = ST_DRAIN;
            ST_DRAIN: if (drain_done) state_d = ST_DONE;
            ST_DONE:  if (start) state_d = ST_RUN;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state_q     <= ST_IDLE;
            drain_cnt_q <= '0;
        end else begin
            state_q     <= state_d;
            drain_cnt_q <= (state_q == ST_DRAIN) ? drain_cnt_q + 2'd1 : 2'd0;
        end
    end

    assign ready = (state_q == ST_RUN);
    assign done  = (state_q == ST_DONE);

endmodule

/* verilog/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  logic           start,
    input  logic           instr_valid,
    input  cpu_pkg::word_t instr,
    output logic           ready,
    output cpu_pkg::wb_t   wb,
    output logic           done
);
    import cpu_pkg::*;

    logic  accept;
    logic  clear_pc;
    logic  halt_seen;
    word_t pc;
    dec_t  dec;
    word_t gp [`NUM_GP];
    word_t sr [`NUM_SR];

    // An instruction is taken only while the core is running.
    assign accept = instr_valid && ready;

    // ####################################################################
    // Control and fetch side
    // ####################################################################

    cpu_control u_cpu_control (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .start     (start),
        .halt_seen (halt_seen),
        .ready     (ready),
        .done      (done),
        .clear_pc  (clear_pc)
    );

    cpu_pc_counter u_cpu_pc_counter (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .clear_pc (clear_pc),
        .accept   (accept),
        .pc       (pc)
    );

    // ####################################################################
    // Pipeline
    // ####################################################################

    cpu_decode u_cpu_decode (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .accept    (accept),
        .instr     (instr),
        .pc        (pc),
        .dec       (dec),
        .halt_seen (halt_seen)
    );

    cpu_execute u_cpu_execute (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .dec    (dec),
        .gp     (gp),
        .sr     (sr),
        .wb     (wb)
    );

    cpu_regfile u_cpu_regfile (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .wb     (wb),
        .gp     (gp),
        .sr     (sr)
    );

endmodule

/* verilog/cpu_decode.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_decode (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  logic           accept,
    input  cpu_pkg::word_t instr,
    input  cpu_pkg::word_t pc,
    output cpu_pkg::dec_t  dec,
    output logic           halt_seen
);
    import cpu_pkg::*;

    logic [`SIZE_OPC-1:0] opc_raw;
    opc_e                 opc;

    assign opc_raw = instr[`POS_OPC +: `SIZE_OPC];

    // Only known codes pass, anything else becomes a NOP.
    always_comb begin
        case (opc_raw)
            OPC_MOV, OPC_ADD, OPC_SUB, OPC_NOT,
            OPC_AND, OPC_OR, OPC_XOR,
            OPC_MOVI, OPC_MOVIS, OPC_LUI,
            OPC_SRMOV, OPC_SRSET, OPC_HALT: begin
                opc = opc_e'(opc_raw);
            end
            default: begin
                opc = OPC_NOP;
            end
        endcase
    end

    // A cycle without accept leaves a bubble with valid low.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            dec <= '0;
        end else begin
            dec.valid <= accept;
            dec.opc   <= opc;
            dec.tgt   <= instr[`POS_TGT +: `SIZE_REG];
            dec.src   <= instr[`POS_SRC +: `SIZE_REG];
            dec.imm   <= instr[`POS_IMM +: `SIZE_IMM];
            dec.pc    <= pc;
            dec.instr <= instr;
        end
    end

    assign halt_seen = dec.valid && (dec.opc == OPC_HALT);

endmodule

/* verilog/cpu_execute.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_execute (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  cpu_pkg::dec_t  dec,
    input  cpu_pkg::word_t gp [`NUM_GP],
    input  cpu_pkg::word_t sr [`NUM_SR],
    output cpu_pkg::wb_t   wb
);
    import cpu_pkg::*;

    logic [`SIZE_DATA-`SIZE_IMM-1:0] ui_q;
    word_t src_val;
    word_t tgt_val;
    word_t sr_val;
    word_t result;
    logic  writes;
    logic  to_sr;

    // ####################################################################
    // Operand read with bypass
    // ####################################################################

    // The register file is written one cycle after wb, so the previous
    // result is taken from wb directly when the indices match.
    always_comb begin
        src_val = gp[dec.src];
        tgt_val = gp[dec.tgt];
        sr_val  = sr[dec.src[`SR_IDX_W-1:0]];
        if (wb.valid && !wb.is_sr) begin
            if (wb.idx == dec.src) begin
                src_val = wb.value;
            end
            if (wb.idx == dec.tgt) begin
                tgt_val = wb.value;
            end
        end
        if (wb.valid && wb.is_sr && (wb.idx == dec.src) && (wb.idx < `NUM_SR)) begin
            sr_val = wb.value;
        end
    end

    // ####################################################################
    // Operation select
    // ####################################################################

    always_comb begin
        result = '0;
        writes = 1'b1;
        to_sr  = 1'b0;
        case (dec.opc)
            OPC_MOV:   result = src_val;
            OPC_ADD:   result = src_val + tgt_val;
            OPC_SUB:   result = src_val - tgt_val;
            OPC_NOT:   result = ~tgt_val;
            OPC_AND:   result = src_val & tgt_val;
            OPC_OR:    result = src_val | tgt_val;
            OPC_XOR:   result = src_val ^ tgt_val;
            OPC_MOVI:  result = {ui_q, dec.imm};
            OPC_MOVIS: result = {{(`SIZE_DATA-`SIZE_IMM){dec.imm[`SIZE_IMM-1]}}, dec.imm};
            OPC_SRMOV: begin
                result = (dec.src == `SR_INDEX_PC) ? dec.pc : sr_val;
            end
            OPC_SRSET: begin
                result = src_val;
                to_sr  = 1'b1;
            end
            // NOP, LUI and HALT pass through without a register write.
            default:   writes = 1'b0;
        endcase
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ui_q <= '0;
            wb   <= '0;
        end else begin
            if (dec.valid && (dec.opc == OPC_LUI)) begin
                ui_q <= dec.imm;
            end
            wb.valid <= dec.valid && writes;
            wb.is_sr <= to_sr;
            wb.idx   <= dec.tgt;
            wb.value <= result;
            wb.pc    <= dec.pc;
        end
    end

endmodule

/* verilog/cpu_pc_counter.sv */
`timescale 1ns/1ps

module cpu_pc_counter (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  logic           clear_pc,
    input  logic           accept,
    output cpu_pkg::word_t pc
);

    // The pc numbers accepted instructions, starting at zero after each start.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc <= '0;
        end else if (clear_pc) begin
            pc <= '0;
        end else if (accept) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

/* verilog/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`SIZE_DATA-1:0] word_t;
    typedef logic [`SIZE_IMM-1:0]  imm_t;
    typedef logic [`SIZE_REG-1:0]  reg_idx_t;

    // ####################################################################
    // Opcodes
    // ####################################################################

    // Codes not listed here are executed as NOP.
    typedef enum logic [`SIZE_OPC-1:0] {
        OPC_NOP   = 6'h00,
        OPC_MOV   = 6'h01,
        OPC_ADD   = 6'h02,
        OPC_SUB   = 6'h03,
        OPC_NOT   = 6'h04,
        OPC_AND   = 6'h05,
        OPC_OR    = 6'h06,
        OPC_XOR   = 6'h07,
        OPC_MOVI  = 6'h08,
        OPC_MOVIS = 6'h09,
        OPC_LUI   = 6'h0a,
        OPC_SRMOV = 6'h0b,
        OPC_SRSET = 6'h0c,
        OPC_HALT  = 6'h3f
    } opc_e;

    // ####################################################################
    // Stage records
    // ####################################################################

    // Decode to execute.
    typedef struct packed {
        logic     valid;
        opc_e     opc;
        reg_idx_t tgt;
        reg_idx_t src;
        imm_t     imm;
        word_t    pc;
        word_t    instr;
    } dec_t;

    // Execute to register file and to the core output.
    typedef struct packed {
        logic     valid;
        logic     is_sr;
        reg_idx_t idx;
        word_t    value;
        word_t    pc;
    } wb_t;

endpackage

/* verilog/cpu_regfile.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_regfile (
    input  logic           iw_clk,
    input  logic           iw_rst,
    input  cpu_pkg::wb_t   wb,
    output cpu_pkg::word_t gp [`NUM_GP],
    output cpu_pkg::word_t sr [`NUM_SR]
);

    logic sr_write_ok;

    // Index 0 stands for the pc, and indices past the array do not exist.
    assign sr_write_ok = (wb.idx != `SR_INDEX_PC) && (wb.idx < `NUM_SR);

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < `NUM_GP; i++) begin
                gp[i] <= '0;
            end
            for (int j = 0; j < `NUM_SR; j++) begin
                sr[j] <= '0;
            end
        end else if (wb.valid) begin
            if (!wb.is_sr) begin
                gp[wb.idx] <= wb.value;
            end else if (sr_write_ok) begin
                sr[wb.idx[`SR_IDX_W-1:0]] <= wb.value;
            end
        end
    end

endmodule

/* verilog/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and instruction word width.
`define SIZE_DATA 24
`define SIZE_IMM  12
`define SIZE_OPC  6
`define SIZE_REG  4

// Register file sizes.
`define NUM_GP    16
`define NUM_SR    4
`define SR_IDX_W  2

// Special register 0 is never stored, it reads back as the pc.
`define SR_INDEX_PC 0

// Field positions inside the instruction word.
`define POS_OPC   18
`define POS_TGT   14
`define POS_SRC   10
`define POS_IMM   0

`endif
